//--- project.f
hw/dsi3_sync_pkg.sv
hw/synchronization_if.sv
hw/synchronization_manager_block.sv
hw/syncb_input_synchronizer.sv
hw/dsi3_sync_master.sv
hw/synchronization_manager.sv
sim/tb_synchronization_manager.sv

//--- Bender.yml
package:
  name: synchronization_manager

sources:
  # RTL in compile order
  - files:
      - hw/dsi3_sync_pkg.sv
      - hw/synchronization_if.sv
      - hw/synchronization_manager_block.sv
      - hw/syncb_input_synchronizer.sv
      - hw/dsi3_sync_master.sv
      - hw/synchronization_manager.sv

  # testbench
  - target: simulation
    files:
      - sim/tb_synchronization_manager.sv

//--- sim/tb_synchronization_manager.sv
`timescale 1ns/1ns

module tb_synchronization_manager;

    localparam int CH              = dsi3_sync_pkg::DSI3_CHANNELS;
    localparam int PULSE_US        = dsi3_sync_pkg::SYNC_PULSE_US_DEFAULT;
    localparam int TIMEOUT_US      = dsi3_sync_pkg::SYNC_TIMEOUT_US_DEFAULT;
    localparam int N_ROUNDS        = 40;
    localparam int N_TESTS         = 4 + N_ROUNDS;
    localparam int WATCHDOG_CYCLES = N_TESTS * (TIMEOUT_US + 10) * 5 + 200;

    logic                   clk;
    logic                   arst_n;
    logic [CH-1:0]          register_sync;
    logic [CH-1:0]          channel_waiting;
    logic [CH-1:0][CH-1:0]  sync_mask;
    logic                   sync_master;
    logic                   tick_1us;
    logic                   ext_syncb;
    logic                   syncb_pad_in;
    logic                   syncb_pad_out;
    logic                   syncb_pad_oe;
    logic                   syncb_pad_pd;
    logic [CH-1:0]          sync_start;
    logic [CH-1:0]          sync_error;
    logic                   syncb;

    // reference model state
    dsi3_sync_pkg::sync_block_state_e m_state [CH];
    logic [CH-1:0][CH-1:0]  m_mask;
    int                     m_cnt [CH];
    logic [CH-1:0]          exp_start;
    logic [CH-1:0]          exp_error;
    logic                   m_pulse;
    int                     m_pcnt;
    logic                   m_s0;
    logic                   m_s1;
    logic                   m_sd;
    logic                   m_fall;

    int                     fire_events;
    int                     tick_div;
    int                     seed;

    synchronization_manager #(
        .P_CHANNELS   (CH),
        .P_PULSE_US   (PULSE_US),
        .P_TIMEOUT_US (TIMEOUT_US)
    ) dut0 (
        .i_clk             (clk),
        .i_arst_n          (arst_n),
        .i_register_sync   (register_sync),
        .i_channel_waiting (channel_waiting),
        .i_sync_mask       (sync_mask),
        .i_sync_master     (sync_master),
        .i_tick_1us        (tick_1us),
        .i_syncb_pad_in    (syncb_pad_in),
        .o_syncb_pad_out   (syncb_pad_out),
        .o_syncb_pad_oe    (syncb_pad_oe),
        .o_syncb_pad_pd    (syncb_pad_pd),
        .o_sync_start      (sync_start),
        .o_sync_error      (sync_error),
        .o_syncb           (syncb)
    );

    // the pad follows the DUT driver when enabled and the external SYNCB otherwise
    assign syncb_pad_in = syncb_pad_oe ? syncb_pad_out : ext_syncb;

    always #10 clk = ~clk;

    // one tick every 5 cycles stands in for a microsecond
    always @(negedge clk) begin
        tick_div = (tick_div == 4) ? 0 : tick_div + 1;
        tick_1us = (tick_div == 4);
    end

    // any channel whose whole mask, itself included, is waiting
    function automatic logic expected_fire(input logic [CH-1:0] reg_flags,
                                           input logic [CH-1:0] waiting,
                                           input logic [CH-1:0][CH-1:0] masks);
        logic fire;
        fire = 1'b0;
        for (int p = 0; p < CH; p++) begin
            if (reg_flags[p] && waiting[p] && ((masks[p] & waiting) == masks[p])) begin
                fire = 1'b1;
            end
        end
        return fire;
    endfunction

    function automatic string state_list();
        string s;
        s = "";
        for (int c = 0; c < CH; c++) begin
            s = {s, " ", m_state[c].name()};
        end
        return s;
    endfunction

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic reset_model();
        for (int c = 0; c < CH; c++) begin
            m_state[c] = dsi3_sync_pkg::SB_IDLE;
            m_cnt[c]   = 0;
        end
        m_mask    = '0;
        exp_start = '0;
        exp_error = '0;
        m_pulse   = 1'b0;
        m_pcnt    = 0;
        m_s0      = 1'b1;
        m_s1      = 1'b1;
        m_sd      = 1'b1;
        m_fall    = 1'b0;
    endtask

    task automatic step_model();
        logic [CH-1:0] reg_flags;
        logic [CH-1:0] waiting_now;
        logic          fire_now;
        logic          fall_now;
        logic          pad_now;
        for (int c = 0; c < CH; c++) begin
            reg_flags[c]   = (m_state[c] != dsi3_sync_pkg::SB_IDLE);
            waiting_now[c] = (m_state[c] == dsi3_sync_pkg::SB_WAITING);
        end
        fire_now = expected_fire(reg_flags, waiting_now, m_mask);
        fall_now = m_fall;
        pad_now  = sync_master ? !m_pulse : ext_syncb;
        for (int c = 0; c < CH; c++) begin
            exp_start[c] = 1'b0;
            // registering a busy channel is an error and the old mask stays
            exp_error[c] = register_sync[c] && reg_flags[c];
            case (m_state[c])
                dsi3_sync_pkg::SB_IDLE: begin
                    if (register_sync[c]) begin
                        m_mask[c]  = sync_mask[c];
                        m_state[c] = dsi3_sync_pkg::SB_REGISTERED;
                    end
                end
                dsi3_sync_pkg::SB_REGISTERED: begin
                    if (channel_waiting[c]) begin
                        m_cnt[c]   = 0;
                        m_state[c] = dsi3_sync_pkg::SB_WAITING;
                    end
                end
                default: begin
                    if (fall_now) begin
                        exp_start[c] = 1'b1;
                        m_mask[c]    = '0;
                        m_state[c]   = dsi3_sync_pkg::SB_IDLE;
                    end else if (tick_1us && m_cnt[c] == TIMEOUT_US - 1) begin
                        exp_error[c] = 1'b1;
                        m_mask[c]    = '0;
                        m_state[c]   = dsi3_sync_pkg::SB_IDLE;
                    end else if (tick_1us) begin
                        m_cnt[c]++;
                    end
                end
            endcase
        end
        if (!m_pulse) begin
            if (fire_now && sync_master) begin
                m_pulse = 1'b1;
                m_pcnt  = 0;
                fire_events++;
            end
        end else if (tick_1us) begin
            if (m_pcnt == PULSE_US - 1) begin
                m_pulse = 1'b0;
            end else begin
                m_pcnt++;
            end
        end
        // two sync flops plus the edge register
        m_fall = m_sd & ~m_s1;
        m_sd   = m_s1;
        m_s1   = m_s0;
        m_s0   = pad_now;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reset_model();
        end else begin
            step_model();
        end
    end

    // compare the registered DUT outputs with the model once per cycle
    always @(negedge clk) begin
        if (arst_n) begin
            check_eq(sync_start, exp_start, {"sync start, model states", state_list()});
            check_eq(sync_error, exp_error, {"sync error, model states", state_list()});
            check_eq(syncb_pad_out, !m_pulse, "SYNCB pad output");
            check_eq(syncb, m_s1, "synchronized SYNCB level");
        end
    end

    task automatic register_channels(input logic [CH-1:0] chans, input logic [CH-1:0] mask);
        @(negedge clk);
        for (int c = 0; c < CH; c++) begin
            if (chans[c]) begin
                sync_mask[c] = mask;
            end
        end
        register_sync = chans;
        @(negedge clk);
        register_sync = '0;
    endtask

    task automatic wait_pulse(input bit want_error, input logic [CH-1:0] chans,
                              input int limit, output int cycles);
        logic [CH-1:0] seen;
        cycles = 0;
        seen   = '0;
        while (seen != chans) begin
            @(negedge clk);
            cycles++;
            seen = want_error ? (sync_error & chans) : (sync_start & chans);
            if (seen != chans && cycles >= limit) begin
                $display("timed out after %0d cycles waiting for a %s pulse on channels %b",
                         cycles, want_error ? "error" : "start", chans);
                $display("Done: errors found");
                $fatal(1, "pulse wait timeout");
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $fatal(1, "watchdog");
    end

    initial begin
        int            cycles;
        logic [31:0]   rnd;
        clk             = 1'b0;
        arst_n          = 1'b0;
        register_sync   = '0;
        channel_waiting = '0;
        sync_mask       = '0;
        sync_master     = 1'b1;
        tick_1us        = 1'b0;
        tick_div        = 0;
        ext_syncb       = 1'b1;
        fire_events     = 0;
        seed            = 32'h9c88_fd0c;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // master fire on channels 0 and 2
        register_channels(4'b0101, 4'b0101);
        channel_waiting[0] = 1'b1;
        repeat (3) @(negedge clk);
        channel_waiting[2] = 1'b1;
        wait_pulse(1'b0, 4'b0101, 20, cycles);
        // one cycle to take the level and five from fire to start
        check_eq(cycles, 6, "start latency in master mode");
        channel_waiting = '0;
        repeat (PULSE_US * 5 + 5) @(negedge clk);

        // only half of the mask waits so channel 1 times out
        register_channels(4'b0010, 4'b1010);
        channel_waiting[1] = 1'b1;
        wait_pulse(1'b1, 4'b0010, TIMEOUT_US * 5 + 10, cycles);
        check_eq(cycles > (TIMEOUT_US - 1) * 5, 1, "timeout came too early");
        channel_waiting = '0;

        // second registration is flagged and the first mask is kept
        register_channels(4'b0001, 4'b0011);
        register_channels(4'b0010, 4'b0111);
        register_channels(4'b0001, 4'b0001);
        check_eq(sync_error[0], 1, "error on double registration");
        @(negedge clk);
        check_eq(sync_error[0], 0, "double registration error is one cycle");
        channel_waiting = 4'b0001;
        repeat (10) @(negedge clk);
        check_eq(syncb_pad_out, 1, "no fire with only channel 0 waiting");
        channel_waiting = 4'b0011;
        wait_pulse(1'b0, 4'b0011, 20, cycles);
        check_eq(cycles, 6, "start latency after double registration");
        channel_waiting = '0;
        repeat (PULSE_US * 5 + 5) @(negedge clk);

        // in slave mode an external device pulls SYNCB
        sync_master = 1'b0;
        #1;
        check_eq(syncb_pad_oe, 0, "pad output enable in slave mode");
        check_eq(syncb_pad_pd, 1, "pad pull-down in slave mode");
        register_channels(4'b0011, 4'b0011);
        channel_waiting = 4'b0011;
        repeat (10) @(negedge clk);
        ext_syncb = 1'b0;
        @(negedge clk);
        check_eq(syncb, 1, "SYNCB level one cycle after the pad falls");
        @(negedge clk);
        check_eq(syncb, 0, "SYNCB level two cycles after the pad falls");
        wait_pulse(1'b0, 4'b0011, 5, cycles);
        check_eq(cycles + 2, 4, "start latency in slave mode");
        channel_waiting = '0;
        repeat (4) @(negedge clk);
        ext_syncb = 1'b1;
        repeat (4) @(negedge clk);
        sync_master = 1'b1;
        #1;
        check_eq(syncb_pad_oe, 1, "pad output enable in master mode");
        check_eq(syncb_pad_pd, 0, "pad pull-down in master mode");

        // random masks and waiting patterns checked against the model
        fire_events = 0;
        for (int round = 0; round < N_ROUNDS; round++) begin
            @(negedge clk);
            for (int c = 0; c < CH; c++) begin
                rnd          = $random(seed);
                sync_mask[c] = rnd[CH-1:0] | (CH'(1) << c);
            end
            rnd           = $random(seed);
            register_sync = rnd[CH-1:0];
            @(negedge clk);
            register_sync   = '0;
            rnd             = $random(seed);
            channel_waiting = rnd[CH-1:0];
            repeat ((TIMEOUT_US + 2) * 5) @(negedge clk);
            channel_waiting = '0;
        end
        check_eq(fire_events != 0, 1, "random rounds gave at least one SYNCB pulse");
        $display("random rounds done, %0d SYNCB pulses", fire_events);

        repeat (5) @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- hw/synchronization_manager.sv
`timescale 1ns/1ns

module synchronization_manager #(
    parameter int P_CHANNELS   = dsi3_sync_pkg::DSI3_CHANNELS,
    parameter int P_PULSE_US   = dsi3_sync_pkg::SYNC_PULSE_US_DEFAULT,
    parameter int P_TIMEOUT_US = dsi3_sync_pkg::SYNC_TIMEOUT_US_DEFAULT
) (
    input  logic                                 i_clk,
    input  logic                                 i_arst_n,
    input  logic [P_CHANNELS-1:0]                i_register_sync,
    input  logic [P_CHANNELS-1:0]                i_channel_waiting,
    input  logic [P_CHANNELS-1:0][P_CHANNELS-1:0] i_sync_mask,
    input  logic                                 i_sync_master,
    input  logic                                 i_tick_1us,
    input  logic                                 i_syncb_pad_in,
    output logic                                 o_syncb_pad_out,
    output logic                                 o_syncb_pad_oe,
    output logic                                 o_syncb_pad_pd,
    output logic [P_CHANNELS-1:0]                o_sync_start,
    output logic [P_CHANNELS-1:0]                o_sync_error,
    output logic                                 o_syncb
);

    logic [P_CHANNELS-1:0] chan_waiting;
    logic [P_CHANNELS-1:0] fire_per_channel;
    logic                  fire;
    logic                  syncb_out;
    logic                  syncb_level;
    logic                  syncb_fall;

    for (genvar c = 0; c < P_CHANNELS; c++) begin : g_channel
        synchronization_if #(
            .P_CHANNELS (P_CHANNELS)
        ) sync_if ();

        // every block sees the same edge and time base
        assign sync_if.fire_seen    = syncb_fall;
        assign sync_if.timeout_tick = i_tick_1us;

        assign chan_waiting[c] = sync_if.waiting;

        // channel c is registered and waiting, and so is everyone in its mask
        assign fire_per_channel[c] = sync_if.registered_channels[P_CHANNELS]
                                   & chan_waiting[c]
                                   & (&(~sync_if.registered_channels[P_CHANNELS-1:0]
                                        | chan_waiting));

        synchronization_manager_block #(
            .P_CHANNELS   (P_CHANNELS),
            .P_TIMEOUT_US (P_TIMEOUT_US)
        ) u_block (
            .i_clk             (i_clk),
            .i_arst_n          (i_arst_n),
            .i_register_sync   (i_register_sync[c]),
            .i_sync_mask       (i_sync_mask[c]),
            .i_channel_waiting (i_channel_waiting[c]),
            .sync              (sync_if),
            .o_sync_start      (o_sync_start[c]),
            .o_sync_error      (o_sync_error[c])
        );
    end

    assign fire = |fire_per_channel;

    // the pad is sampled in master and slave mode alike
    syncb_input_synchronizer u_syncb_sync (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_in     (i_syncb_pad_in),
        .o_level  (syncb_level),
        .o_fall   (syncb_fall)
    );

    dsi3_sync_master #(
        .P_PULSE_US (P_PULSE_US)
    ) u_sync_master (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_fire        (fire),
        .i_tick_1us    (i_tick_1us),
        .i_sync_master (i_sync_master),
        .o_syncb_out   (syncb_out)
    );

    // master drives the line, a slave only listens with the pull-down on
    assign o_syncb_pad_out = syncb_out;
    assign o_syncb_pad_oe  = i_sync_master;
    assign o_syncb_pad_pd  = ~i_sync_master;

    assign o_syncb = syncb_level;

endmodule

//--- hw/dsi3_sync_master.sv
`timescale 1ns/1ns

module dsi3_sync_master #(
    parameter int P_PULSE_US = dsi3_sync_pkg::SYNC_PULSE_US_DEFAULT
) (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_fire,
    input  logic i_tick_1us,
    input  logic i_sync_master,
    output logic o_syncb_out
);

    localparam int L_CNT_W = $clog2(P_PULSE_US + 1);

    dsi3_sync_pkg::sync_master_state_e state_q;

    logic [L_CNT_W-1:0] pulse_cnt_q;
    logic               pulse_done;

    assign pulse_done = i_tick_1us && (pulse_cnt_q == L_CNT_W'(P_PULSE_US - 1));

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q     <= dsi3_sync_pkg::SM_IDLE;
            pulse_cnt_q <= '0;
        end else begin
            case (state_q)
                dsi3_sync_pkg::SM_IDLE: begin
                    // only a sync master may pull the line
                    if (i_fire && i_sync_master) begin
                        pulse_cnt_q <= '0;
                        state_q     <= dsi3_sync_pkg::SM_PULSE;
                    end
                end
                dsi3_sync_pkg::SM_PULSE: begin
                    // further fire requests are dropped until the pulse ends
                    if (pulse_done) begin
                        state_q <= dsi3_sync_pkg::SM_IDLE;
                    end else if (i_tick_1us) begin
                        pulse_cnt_q <= pulse_cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= dsi3_sync_pkg::SM_IDLE;
                end
            endcase
        end
    end

    // line is low for the whole pulse, straight from the state flop
    assign o_syncb_out = (state_q == dsi3_sync_pkg::SM_IDLE);

endmodule

//--- hw/syncb_input_synchronizer.sv
`timescale 1ns/1ns

module syncb_input_synchronizer (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_in,
    output logic o_level,
    output logic o_fall
);

    // SYNCB idles high, so all stages come out of reset high
    logic [1:0] sync_q;
    logic       level_d_q;
    logic       fall_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sync_q    <= 2'b11;
            level_d_q <= 1'b1;
            fall_q    <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], i_in};
            level_d_q <= sync_q[1];
            // high to low on the synchronized level
            fall_q    <= level_d_q & ~sync_q[1];
        end
    end

    assign o_level = sync_q[1];
    assign o_fall  = fall_q;

endmodule

//--- hw/synchronization_manager_block.sv
`timescale 1ns/1ns

module synchronization_manager_block #(
    parameter int P_CHANNELS   = dsi3_sync_pkg::DSI3_CHANNELS,
    parameter int P_TIMEOUT_US = dsi3_sync_pkg::SYNC_TIMEOUT_US_DEFAULT
) (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_register_sync,
    input  logic [P_CHANNELS-1:0] i_sync_mask,
    input  logic                  i_channel_waiting,
    synchronization_if.block      sync,
    output logic                  o_sync_start,
    output logic                  o_sync_error
);

    localparam int L_CNT_W = $clog2(P_TIMEOUT_US + 1);

    dsi3_sync_pkg::sync_block_state_e state_q;

    logic [P_CHANNELS:0] mask_q;
    logic [L_CNT_W-1:0]  tick_cnt_q;
    logic                start_q;
    logic                error_q;
    logic                reg_error;
    logic                timeout_hit;

    // a new registration is only accepted in idle
    assign reg_error = i_register_sync && (state_q != dsi3_sync_pkg::SB_IDLE);

    // last tick of the wait window, a SYNCB edge in the same cycle wins
    assign timeout_hit = (state_q == dsi3_sync_pkg::SB_WAITING) && !sync.fire_seen
                         && sync.timeout_tick
                         && (tick_cnt_q == L_CNT_W'(P_TIMEOUT_US - 1));

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q    <= dsi3_sync_pkg::SB_IDLE;
            mask_q     <= '0;
            tick_cnt_q <= '0;
            start_q    <= 1'b0;
            error_q    <= 1'b0;
        end else begin
            start_q <= 1'b0;
            error_q <= reg_error || timeout_hit;
            case (state_q)
                dsi3_sync_pkg::SB_IDLE: begin
                    if (i_register_sync) begin
                        mask_q  <= {1'b1, i_sync_mask};
                        state_q <= dsi3_sync_pkg::SB_REGISTERED;
                    end
                end
                dsi3_sync_pkg::SB_REGISTERED: begin
                    if (i_channel_waiting) begin
                        tick_cnt_q <= '0;
                        state_q    <= dsi3_sync_pkg::SB_WAITING;
                    end
                end
                dsi3_sync_pkg::SB_WAITING: begin
                    if (sync.fire_seen) begin
                        start_q <= 1'b1;
                        mask_q  <= '0;
                        state_q <= dsi3_sync_pkg::SB_IDLE;
                    end else if (timeout_hit) begin
                        mask_q  <= '0;
                        state_q <= dsi3_sync_pkg::SB_IDLE;
                    end else if (sync.timeout_tick) begin
                        tick_cnt_q <= tick_cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= dsi3_sync_pkg::SB_IDLE;
                end
            endcase
        end
    end

    assign sync.registered_channels = mask_q;
    assign sync.waiting             = (state_q == dsi3_sync_pkg::SB_WAITING);

    assign o_sync_start = start_q;
    assign o_sync_error = error_q;

endmodule

//--- hw/synchronization_if.sv
`timescale 1ns/1ns

interface synchronization_if #(
    parameter int P_CHANNELS = dsi3_sync_pkg::DSI3_CHANNELS
) ();

    // latched mask, top bit marks an active registration
    logic [P_CHANNELS:0] registered_channels;
    // channel has reached its sync point
    logic                waiting;
    // synchronized SYNCB falling edge, one cycle
    logic                fire_seen;
    // 1 us time base for the wait timeout
    logic                timeout_tick;

    modport block (
        output registered_channels,
        output waiting,
        input  fire_seen,
        input  timeout_tick
    );

    modport manager (
        input  registered_channels,
        input  waiting,
        output fire_seen,
        output timeout_tick
    );

endinterface

//--- hw/dsi3_sync_pkg.sv
package dsi3_sync_pkg;

    // number of DSI3 bus channels sharing one SYNCB line
    parameter int DSI3_CHANNELS = 4;

    // width of the SYNCB low pulse, in 1 us ticks
    parameter int SYNC_PULSE_US_DEFAULT = 3;

    // ticks a channel may wait at its sync point before it flags an error
    parameter int SYNC_TIMEOUT_US_DEFAULT = 20;

    // one bit per channel that has to start together
    typedef logic [DSI3_CHANNELS-1:0] sync_channel_mask_t;

    // per-channel block FSM
    typedef enum logic [1:0] {
        SB_IDLE       = 2'b00,
        SB_REGISTERED = 2'b01,
        SB_WAITING    = 2'b10
    } sync_block_state_e;

    // SYNCB pulse generator FSM
    typedef enum logic {
        SM_IDLE  = 1'b0,
        SM_PULSE = 1'b1
    } sync_master_state_e;

endpackage
